//--- include/nocArb_defs.svh
`ifndef NOC_ARB_DEFS_SVH
`define NOC_ARB_DEFS_SVH

// Input ports Local through South feeding this output.
`define NOC_NUM_PORTS 5

// Packet length field and hold timer width.
`define NOC_LEN_W 12

// Flit payload width.
`define NOC_PAYLOAD_W 16

// Flit identifier of a header flit.
`define NOC_FLIT_HEAD 1

`endif

//--- src/nocArbPkg.sv
`include "nocArb_defs.svh"

package nocArbPkg;

  // Input port order, also the priority order out of idle.
  typedef enum logic [2:0]
  {
    Local,
    North,
    East,
    West,
    South
  } portIdx_t;

  typedef logic [2:0] flitId_t;

  // A header flit carries the packet length in the low payload bits.
  typedef struct packed
  {
    flitId_t                   id;
    logic [`NOC_PAYLOAD_W-1:0] payload;
  } flit_t;

  // One-hot arbiter state.
  // Bit 0 is idle, bits 1 to 5 are Local through South.
  typedef logic [`NOC_NUM_PORTS:0] grant_t;

endpackage

//--- src/packetTimer.sv
`timescale 1ns/1ps
`include "nocArb_defs.svh"

module packetTimer
  import nocArbPkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  flit_t                 flit,
  input  logic [`NOC_LEN_W-1:0] holdCap,
  input  logic                  runTimer,
  output logic                  timesUp
);

  logic [`NOC_LEN_W-1:0] count;
  logic [`NOC_LEN_W-1:0] limit;
  logic [`NOC_LEN_W-1:0] pktLen;
  logic                  isHead;

  assign pktLen = flit.payload[`NOC_LEN_W-1:0];  // Length field of a header.
  assign isHead = (flit.id == flitId_t'(`NOC_FLIT_HEAD));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
      limit <= '0;
    end
    else
    begin
      if (isHead)
        limit <= (pktLen < holdCap) ? pktLen : holdCap;  // Cap bounds every packet.
      if (runTimer)
        count <= count + 1'b1;  // One more held cycle.
      else
        count <= '0;
    end
  end

  // Stays high while the count sits on the limit.
  assign timesUp = (count == limit);

endmodule

//--- src/outputArbiter.sv
`timescale 1ns/1ps
`include "nocArb_defs.svh"

module outputArbiter
  import nocArbPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`NOC_NUM_PORTS-1:0] reqs,
  input  logic [`NOC_NUM_PORTS-1:0] timesUp,
  output grant_t                    grant,
  output logic [`NOC_NUM_PORTS-1:0] runTimer
);

  localparam grant_t grantIdle  = grant_t'(1);
  localparam grant_t grantLocal = grant_t'(1) << (int'(Local) + 1);
  localparam grant_t grantNorth = grant_t'(1) << (int'(North) + 1);
  localparam grant_t grantEast  = grant_t'(1) << (int'(East) + 1);
  localparam grant_t grantWest  = grant_t'(1) << (int'(West) + 1);
  localparam grant_t grantSouth = grant_t'(1) << (int'(South) + 1);

  grant_t   grantNext;
  portIdx_t holder;
  logic     stateIdle;
  logic     stateLegal;

  // First requester found walking span ports from first, wrapping round.
  function automatic grant_t rotatePick(
    input logic [`NOC_NUM_PORTS-1:0] req,
    input int unsigned               first,
    input int unsigned               span
  );
    grant_t      pick;
    int unsigned idx;
    logic        found;
    pick  = grantIdle;
    found = 1'b0;
    for (int unsigned k = 0; k < span; k++)
    begin
      idx = (first + k) % `NOC_NUM_PORTS;
      if (!found && req[idx])
      begin
        pick  = grant_t'(1) << (idx + 1);
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  // Which port owns the output right now.
  always_comb
  begin
    holder     = Local;
    stateIdle  = 1'b0;
    stateLegal = 1'b1;
    case (grant)
      grantIdle:
        stateIdle = 1'b1;
      grantLocal:
        holder = Local;
      grantNorth:
        holder = North;
      grantEast:
        holder = East;
      grantWest:
        holder = West;
      grantSouth:
        holder = South;
      default:
        stateLegal = 1'b0;  // Not one-hot.
    endcase
  end

  always_comb
  begin
    runTimer  = '0;
    grantNext = grantIdle;
    if (!stateLegal)
    begin
      grantNext = grantIdle;
    end
    else if (stateIdle)
    begin
      grantNext = rotatePick(reqs, int'(Local), `NOC_NUM_PORTS);  // Local first.
    end
    else if (reqs[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1;  // Holder keeps the output.
      grantNext        = grant;
    end
    else
    begin
      // Skip the holder, it rejoins through idle.
      grantNext = rotatePick(reqs, int'(holder) + 1, `NOC_NUM_PORTS - 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= grantIdle;
    else
      grant <= grantNext;
  end

endmodule

//--- src/arbConfig.sv
`timescale 1ns/1ps
`include "nocArb_defs.svh"

module arbConfig
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cfgWrite,
  input  logic                      cfgAddr,
  input  logic [`NOC_LEN_W-1:0]     cfgData,
  output logic [`NOC_NUM_PORTS-1:0] portEnable,
  output logic [`NOC_LEN_W-1:0]     holdCap
);

  localparam logic addrEnable  = 1'b0;
  localparam logic addrHoldCap = 1'b1;

  // Written on a single-cycle strobe with no acknowledge.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      portEnable <= '1;  // All ports on.
      holdCap    <= '1;  // No cap below the length field.
    end
    else if (cfgWrite)
    begin
      case (cfgAddr)
        addrEnable:
          portEnable <= cfgData[`NOC_NUM_PORTS-1:0];
        addrHoldCap:
          holdCap <= cfgData;
      endcase
    end
  end

endmodule

//--- src/flitCrossbar.sv
`timescale 1ns/1ps
`include "nocArb_defs.svh"

module flitCrossbar
  import nocArbPkg::*;
#(
  parameter type payloadT = flit_t
)
(
  input  grant_t                    grant,
  input  logic [`NOC_NUM_PORTS-1:0] reqs,
  input  payloadT                   inPayloads [`NOC_NUM_PORTS],
  output logic                      outValid,
  output payloadT                   outPayload
);

  logic [$bits(payloadT)-1:0] muxAcc;

  // One-hot OR mux that gives zero when idle.
  always_comb
  begin
    muxAcc   = '0;
    outValid = 1'b0;
    for (int p = 0; p < `NOC_NUM_PORTS; p++)
    begin
      if (grant[p + 1])
      begin
        muxAcc   = muxAcc | inPayloads[p];
        outValid = outValid | reqs[p];  // Granted port still asking.
      end
    end
  end

  assign outPayload = payloadT'(muxAcc);

endmodule

//--- src/nocOutputPort.sv
`timescale 1ns/1ps
`include "nocArb_defs.svh"

module nocOutputPort
  import nocArbPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`NOC_NUM_PORTS-1:0] reqs,
  input  flit_t                     inFlits [`NOC_NUM_PORTS],
  input  logic                      cfgWrite,
  input  logic                      cfgAddr,
  input  logic [`NOC_LEN_W-1:0]     cfgData,
  output grant_t                    grant,
  output logic                      outValid,
  output flit_t                     outFlit
);

  logic [`NOC_NUM_PORTS-1:0] portEnable;
  logic [`NOC_LEN_W-1:0]     holdCap;
  logic [`NOC_NUM_PORTS-1:0] effReqs;
  logic [`NOC_NUM_PORTS-1:0] runTimer;
  logic [`NOC_NUM_PORTS-1:0] timesUp;

  assign effReqs = reqs & portEnable;  // Disabled ports never ask.

  arbConfig i_arbConfig
  (
    .clk        (clk),
    .rst        (rst),
    .cfgWrite   (cfgWrite),
    .cfgAddr    (cfgAddr),
    .cfgData    (cfgData),
    .portEnable (portEnable),
    .holdCap    (holdCap)
  );

  outputArbiter i_outputArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (effReqs),
    .timesUp  (timesUp),
    .grant    (grant),
    .runTimer (runTimer)
  );

  // One hold timer per input port.
  for (genvar p = 0; p < `NOC_NUM_PORTS; p++)
  begin : g_timer
    packetTimer i_packetTimer
    (
      .clk      (clk),
      .rst      (rst),
      .flit     (inFlits[p]),
      .holdCap  (holdCap),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );
  end

  flitCrossbar #(.payloadT(flit_t)) i_flitCrossbar
  (
    .grant      (grant),
    .reqs       (effReqs),
    .inPayloads (inFlits),
    .outValid   (outValid),
    .outPayload (outFlit)
  );

endmodule

//--- verif/nocOutputPort_tb.sv
`timescale 1ns/1ps
`include "nocArb_defs.svh"

module nocOutputPort_tb
  import nocArbPkg::*;
();

  localparam int vecFields    = 12;  // Fields per vector line.
  localparam int maxVecs      = 256;
  localparam int resetCycles  = 8;
  localparam int timeoutSlack = 50;

  // Field offsets within one vector.
  localparam int fldReqs    = 0;
  localparam int fldFlit    = 1;  // Five flits from Local to South.
  localparam int fldWrite   = 6;
  localparam int fldAddr    = 7;
  localparam int fldData    = 8;
  localparam int fldGrant   = 9;
  localparam int fldValid   = 10;
  localparam int fldOutFlit = 11;

  logic                      clk;
  logic                      rst;
  logic [`NOC_NUM_PORTS-1:0] reqs;
  flit_t                     inFlits [`NOC_NUM_PORTS];
  logic                      cfgWrite;
  logic                      cfgAddr;
  logic [`NOC_LEN_W-1:0]     cfgData;
  grant_t                    grant;
  logic                      outValid;
  flit_t                     outFlit;

  logic [31:0] vecMem [0:vecFields*maxVecs-1];
  int          numVecs;
  int          cycleLimit;
  int          cycleCount;
  int          grantErrors;
  int          validErrors;
  int          flitErrors;
  int          setupErrors;

  nocOutputPort i_nocOutputPort
  (
    .clk      (clk),
    .rst      (rst),
    .reqs     (reqs),
    .inFlits  (inFlits),
    .cfgWrite (cfgWrite),
    .cfgAddr  (cfgAddr),
    .cfgData  (cfgData),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period.
  end

  task automatic compareGrant(input grant_t expected, input grant_t actual);
    if (actual !== expected)
    begin
      grantErrors++;
      $display("ERR %0d ns grant expected %h actual %h", $time, expected, actual);
    end
  endtask

  task automatic compareValid(input logic expected, input logic actual);
    if (actual !== expected)
    begin
      validErrors++;
      $display("ERR %0d ns outValid expected %b actual %b", $time, expected, actual);
    end
  endtask

  task automatic compareFlit(input flit_t expected, input flit_t actual);
    if (actual !== expected)
    begin
      flitErrors++;
      $display("ERR %0d ns outFlit expected %h actual %h", $time, expected, actual);
    end
  endtask

  // Expected grant is one-hot, so a zero or unknown field ends the table.
  function automatic int countVectors();
    int n;
    n = 0;
    while (n < maxVecs && !$isunknown(vecMem[n*vecFields + fldGrant])
           && vecMem[n*vecFields + fldGrant] != 0)
      n++;
    return n;
  endfunction

  task automatic driveVector(input int v);
    int base;
    base     = v * vecFields;
    reqs     = vecMem[base + fldReqs][`NOC_NUM_PORTS-1:0];
    cfgWrite = vecMem[base + fldWrite][0];
    cfgAddr  = vecMem[base + fldAddr][0];
    cfgData  = vecMem[base + fldData][`NOC_LEN_W-1:0];
    for (int p = 0; p < `NOC_NUM_PORTS; p++)
      inFlits[p] = flit_t'(vecMem[base + fldFlit + p][$bits(flit_t)-1:0]);
  endtask

  task automatic checkVector(input int v);
    int base;
    base = v * vecFields;
    compareGrant(grant_t'(vecMem[base + fldGrant][`NOC_NUM_PORTS:0]), grant);
    compareValid(vecMem[base + fldValid][0], outValid);
    compareFlit(flit_t'(vecMem[base + fldOutFlit][$bits(flit_t)-1:0]), outFlit);
  endtask

  task automatic reportCounts();
    $display("Vectors %0d, grant errors %0d, valid errors %0d, flit errors %0d, setup errors %0d",
             numVecs, grantErrors, validErrors, flitErrors, setupErrors);
  endtask

  // Stops a run that never reaches the end of the table.
  initial
  begin
    cycleCount = 0;
    wait (cycleLimit > 0);
    while (cycleCount < cycleLimit)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Run stopped after %0d cycles before all vectors were applied.", cycleCount);
    reportCounts();
    $display("Errors found");
    $finish;
  end

  initial
  begin
    rst         = 1'b1;
    reqs        = '0;
    cfgWrite    = 1'b0;
    cfgAddr     = 1'b0;
    cfgData     = '0;
    grantErrors = 0;
    validErrors = 0;
    flitErrors  = 0;
    setupErrors = 0;
    for (int p = 0; p < `NOC_NUM_PORTS; p++)
      inFlits[p] = '0;
    $readmemh("verif/arbiter_input.txt", vecMem);
    numVecs    = countVectors();
    cycleLimit = numVecs + timeoutSlack;
    if (numVecs == 0)
    begin
      setupErrors++;
      $display("No vectors could be read from verif/arbiter_input.txt.");
    end
    repeat (resetCycles) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int v = 0; v < numVecs; v++)
    begin
      driveVector(v);
      #8;  // Just before the next edge.
      checkVector(v);
      @(posedge clk);
      #1;
    end
    reportCounts();
    if (grantErrors + validErrors + flitErrors + setupErrors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- verif/arbiter_input.txt
// reqs flitL flitN flitE flitW flitS cfgWrite cfgAddr cfgData  expGrant expValid expFlit
// One line per cycle after reset, all hex, flits are {id, payload}, header id is 1.
00 2ABCD 21111 22222 23333 24444 0 0 000 01 0 00000
01 2ABCD 21111 22222 23333 24444 0 0 000 01 0 00000
01 2ABCD 21111 22222 23333 24444 0 0 000 02 1 2ABCD
01 2ABCD 21111 22222 23333 24444 0 0 000 01 0 00000
01 2ABCD 21111 22222 23333 24444 0 0 000 02 1 2ABCD
00 2ABCD 21111 22222 23333 24444 0 0 000 01 0 00000
03 10003 21111 22222 23333 24444 0 0 000 01 0 00000
03 10003 21111 22222 23333 24444 0 0 000 02 1 10003
03 10003 21111 22222 23333 24444 0 0 000 02 1 10003
03 10003 21111 22222 23333 24444 0 0 000 02 1 10003
03 10003 21111 22222 23333 24444 0 0 000 02 1 10003
02 10003 21111 22222 23333 24444 0 0 000 04 1 21111
00 10003 21111 22222 23333 24444 0 0 000 01 0 00000
1D 1A001 21111 1B001 1C001 1D001 0 0 000 01 0 00000
1D 1A001 21111 1B001 1C001 1D001 0 0 000 02 1 1A001
1D 1A001 21111 1B001 1C001 1D001 0 0 000 02 1 1A001
1D 1A001 21111 1B001 1C001 1D001 0 0 000 08 1 1B001
1D 1A001 21111 1B001 1C001 1D001 0 0 000 08 1 1B001
1D 1A001 21111 1B001 1C001 1D001 0 0 000 10 1 1C001
1D 1A001 21111 1B001 1C001 1D001 0 0 000 10 1 1C001
10 1A001 21111 1B001 1C001 1D001 0 0 000 20 1 1D001
10 1A001 21111 1B001 1C001 1D001 0 0 000 20 1 1D001
10 1A001 21111 1B001 1C001 1D001 0 0 000 01 0 00000
10 1A001 21111 1B001 1C001 1D001 0 0 000 20 1 1D001
10 1A001 21111 1B001 1C001 1D001 0 0 000 20 1 1D001
00 1A001 21111 1B001 1C001 1D001 0 0 000 01 0 00000
00 1A001 21111 1B001 1C001 1D001 1 1 002 01 0 00000
0C 1A001 21111 1B008 1C001 1D001 0 0 000 01 0 00000
0C 1A001 21111 1B008 1C001 1D001 0 0 000 08 1 1B008
0C 1A001 21111 1B008 1C001 1D001 0 0 000 08 1 1B008
0C 1A001 21111 1B008 1C001 1D001 0 0 000 08 1 1B008
0C 1A001 21111 1B008 1C001 1D001 0 0 000 10 1 1C001
08 1A001 21111 1B008 1C001 1D001 0 0 000 10 1 1C001
06 1A001 21111 1B000 1C001 1D001 1 0 01D 01 0 00000
06 1A001 21111 1B000 1C001 1D001 0 0 000 04 0 21111
06 1A001 21111 1B000 1C001 1D001 0 0 000 08 1 1B000
02 1A001 21111 1B000 1C001 1D001 0 0 000 01 0 00000
11 1A005 21111 1B000 1C001 1D001 1 0 01F 01 0 00000
11 1A005 21111 1B000 1C001 1D001 0 0 000 02 1 1A005
10 1A005 21111 1B000 1C001 1D001 0 0 000 02 0 1A005
10 1A005 21111 1B000 1C001 1D001 0 0 000 20 1 1D001
00 1A005 21111 1B000 1C001 1D001 0 0 000 20 0 1D001
00 1A005 21111 1B000 1C001 1D001 0 0 000 01 0 00000

//--- nocOutputPort.f
+incdir+include
src/nocArbPkg.sv
src/packetTimer.sv
src/outputArbiter.sv
src/arbConfig.sv
src/flitCrossbar.sv
src/nocOutputPort.sv
verif/nocOutputPort_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := nocOutputPort_tb
FILELIST  := nocOutputPort.f

OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log
PASS   := No errors
SRCS   := $(wildcard src/*.sv include/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
